//--- dv/uart_mcont_assertions.sv
// Protocol checks on the UART controller top, attached to every uart_mcont_top instance by bind
`timescale 1ns/1ps

module uart_mcont_assertions (
	input logic                  CLK_BUF,
	input logic                  reset_i,
	input logic                  uart_tx_i,
	input logic                  tx_busy_i,
	input logic                  tx_start_i,
	input mem_map_pkg::int_sig_t int_sig_i
);

	// Count of failed checks
	int fail_cnt = 0;

	// Idle serializer keeps the line high
	assert property (@(posedge CLK_BUF) disable iff (reset_i) !tx_busy_i |-> uart_tx_i)
	else begin
		fail_cnt++;
		$error("uart_tx_o low while the serializer is idle");
	end

	// Start strobe only toward an idle serializer, which turns busy next cycle
	assert property (@(posedge CLK_BUF) disable iff (reset_i)
		tx_start_i |-> !tx_busy_i ##1 tx_busy_i)
	else begin
		fail_cnt++;
		$error("tx_start fired while the serializer was busy, or busy did not follow");
	end

	// Interrupts are single-cycle pulses
	assert property (@(posedge CLK_BUF) disable iff (reset_i)
		int_sig_i.tx_done |=> !int_sig_i.tx_done)
	else begin
		fail_cnt++;
		$error("tx_done held high for more than one cycle");
	end

	assert property (@(posedge CLK_BUF) disable iff (reset_i)
		int_sig_i.rx_byte |=> !int_sig_i.rx_byte)
	else begin
		fail_cnt++;
		$error("rx_byte held high for more than one cycle");
	end

	assert property (@(posedge CLK_BUF) disable iff (reset_i)
		int_sig_i.rx_err |=> !int_sig_i.rx_err)
	else begin
		fail_cnt++;
		$error("rx_err held high for more than one cycle");
	end

endmodule

bind uart_mcont_top uart_mcont_assertions u_assertions (
	.CLK_BUF(CLK_BUF),
	.reset_i(reset_i),
	.uart_tx_i(uart_tx_o),
	.tx_busy_i(tx_busy),
	.tx_start_i(tx_start),
	.int_sig_i(int_sig_o)
);

//--- dv/uart_mcont_tb.sv
// Table-driven testbench for the UART controller subsystem, top module of the simulation
`timescale 1ns/1ps

module uart_mcont_tb;

	localparam int CLK_PERIOD = 40;
	localparam int BIT_CLKS = uart_pkg::CLKS_PER_BIT;
	// Transmit buffer and scratch word for core accesses
	localparam mem_map_pkg::addr_t TX_BUF_ADDR = 11'd16;
	localparam mem_map_pkg::addr_t CORE_ADDR = 11'd300;
	localparam mem_map_pkg::word_t CORE_BASE = 32'h1122_3344;

	typedef enum logic [1:0] {K_CORE, K_TX, K_RX} kind_t;

	// One table row
	// data holds the bytes in lane order, ovl is receive frames sent during a transmit
	typedef struct packed {
		kind_t                 kind;
		int                    n;
		mem_map_pkg::word_t    data;
		mem_map_pkg::byte_en_t be;
		logic                  stop;
		logic                  rnd;
		int                    ovl;
		mem_map_pkg::word_t    exp;
	} entry_t;

	logic CLK_BUF;
	logic reset_i;
	mem_map_pkg::mem_req_t core_req;
	mem_map_pkg::word_t core_rdata;
	logic rx_line;
	logic tx_line;
	mem_map_pkg::int_sig_t int_sig;

	entry_t tbl[$];
	// Bytes seen on the transmit line
	uart_pkg::byte_t tx_seen[$];
	// Expected receive buffer contents, one entry per good byte
	mem_map_pkg::addr_t exp_addr[$];
	int exp_lane[$];
	uart_pkg::byte_t exp_byte[$];
	logic [7:0] rx_count = '0;
	int exp_rx_bytes = 0;
	int exp_rx_errs = 0;
	int exp_tx_done = 0;
	int n_tx_done = 0;
	int n_rx_byte = 0;
	int n_rx_err = 0;
	int frames = 0;
	longint limit_ns = 0;
	integer seed = 32'h2c35;

	uart_mcont_top u_dut (
		.CLK_BUF(CLK_BUF), .reset_i(reset_i), .core_req_i(core_req), .core_rdata_o(core_rdata),
		.uart_rx_i(rx_line), .uart_tx_o(tx_line), .int_sig_o(int_sig)
	);

	initial begin
		CLK_BUF = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_BUF = ~CLK_BUF;
	end

	task automatic stop_run();
		$display("Some tests failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_word(input string name, input mem_map_pkg::word_t got,
			input mem_map_pkg::word_t exp);
		if (got !== exp) begin
			$display("FAILED at %0d ns: %s got %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_byte(input string name, input uart_pkg::byte_t got,
			input uart_pkg::byte_t exp);
		if (got !== exp) begin
			$display("FAILED at %0d ns: %s got %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_int(input string name, input mem_map_pkg::int_sig_t got,
			input mem_map_pkg::int_sig_t exp);
		if (got !== exp) begin
			$display("FAILED at %0d ns: %s got %b, expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	// Pulse and byte tallies
	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("FAILED at %0d ns: %s got %0d, expected %0d", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic core_write(input mem_map_pkg::addr_t addr, input mem_map_pkg::byte_en_t be,
			input mem_map_pkg::word_t wdata);
		@(posedge CLK_BUF);
		#2;
		core_req = '{addr: addr, be: be, wdata: wdata};
		@(posedge CLK_BUF);
		#2;
		core_req.be = '0;
	endtask

	// Read data is valid one cycle after the request
	task automatic core_read(input mem_map_pkg::addr_t addr, output mem_map_pkg::word_t data);
		@(posedge CLK_BUF);
		#2;
		core_req = '{addr: addr, be: '0, wdata: '0};
		@(posedge CLK_BUF);
		@(negedge CLK_BUF);
		data = core_rdata;
	endtask

	// Start, eight data bits LSB first, stop, then one idle bit
	task automatic send_frame(input uart_pkg::byte_t b, input logic stop);
		logic [9:0] bits;
		bits = {stop, b, 1'b0};
		@(posedge CLK_BUF);
		for (int i = 0; i < 10; i++) begin
			#2;
			rx_line = bits[i];
			repeat (BIT_CLKS) @(posedge CLK_BUF);
		end
		#2;
		rx_line = 1'b1;
		repeat (BIT_CLKS) @(posedge CLK_BUF);
	endtask

	// Good bytes land at the count's word and lane
	task automatic send_rx(input uart_pkg::byte_t b, input logic stop);
		if (stop) begin
			exp_addr.push_back(mem_map_pkg::RX_BASE_ADDR + mem_map_pkg::addr_t'(rx_count[7:2]));
			exp_lane.push_back(int'(rx_count[1:0]));
			exp_byte.push_back(b);
			rx_count = rx_count + 8'd1;
			exp_rx_bytes++;
		end else begin
			exp_rx_errs++;
		end
		send_frame(b, stop);
	endtask

	task automatic check_rx();
		mem_map_pkg::word_t rd;
		mem_map_pkg::addr_t addr;
		int lane;
		uart_pkg::byte_t b;
		while (exp_addr.size() > 0) begin
			addr = exp_addr.pop_front();
			lane = exp_lane.pop_front();
			b = exp_byte.pop_front();
			core_read(addr, rd);
			check_byte($sformatf("rx buffer word %0d lane %0d", addr, lane), rd[lane*8 +: 8], b);
		end
		core_read(mem_map_pkg::RX_COUNT_ADDR, rd);
		check_word("rx count word", rd, {24'd0, rx_count});
		check_count("rx_byte pulses", n_rx_byte, exp_rx_bytes);
	endtask

	task automatic run_core(input entry_t e);
		mem_map_pkg::word_t rd;
		core_write(CORE_ADDR, 4'hf, CORE_BASE);
		core_write(CORE_ADDR, e.be, e.data);
		core_read(CORE_ADDR, rd);
		check_word($sformatf("core_rdata_o with be %b", e.be), rd, e.exp);
	endtask

	task automatic run_tx(input entry_t e);
		mem_map_pkg::tx_ctrl_u cmd;
		mem_map_pkg::word_t w;
		mem_map_pkg::word_t rd;
		uart_pkg::byte_t exp_q[$];
		int done_before;
		// Buffer words first, bytes go out in lane order
		for (int k = 0; k < (e.n + 3) / 4; k++) begin
			w = e.rnd ? $random(seed) : e.data;
			core_write(TX_BUF_ADDR + mem_map_pkg::addr_t'(k), 4'hf, w);
			for (int l = 0; l < 4; l++) begin
				if (k * 4 + l < e.n) exp_q.push_back(w[l*8 +: 8]);
			end
		end
		cmd.raw = '0;
		cmd.fields.go = 1'b1;
		cmd.fields.len = 8'(e.n);
		cmd.fields.start = TX_BUF_ADDR;
		tx_seen.delete();
		done_before = n_tx_done;
		exp_tx_done++;
		core_write(mem_map_pkg::TX_CTRL_ADDR, 4'hf, cmd.raw);
		// Receive frames run alongside to load the arbiter
		fork
			wait (n_tx_done != done_before);
			for (int f = 0; f < e.ovl; f++) send_rx(e.data[(f % 4)*8 +: 8], 1'b1);
		join
		check_count("bytes on uart_tx_o", tx_seen.size(), exp_q.size());
		foreach (exp_q[i]) check_byte($sformatf("uart_tx_o byte %0d", i), tx_seen[i], exp_q[i]);
		// Mailbox comes back with only go cleared
		cmd.fields.go = 1'b0;
		core_read(mem_map_pkg::TX_CTRL_ADDR, rd);
		check_word("mailbox word", rd, cmd.raw);
		check_count("tx_done pulses", n_tx_done - done_before, 1);
		if (e.ovl > 0) check_rx();
	endtask

	task automatic run_rx(input entry_t e);
		mem_map_pkg::word_t cnt_before;
		mem_map_pkg::word_t buf_before;
		mem_map_pkg::word_t rd;
		mem_map_pkg::addr_t buf_addr;
		buf_addr = mem_map_pkg::RX_BASE_ADDR + mem_map_pkg::addr_t'(rx_count[7:2]);
		core_read(mem_map_pkg::RX_COUNT_ADDR, cnt_before);
		core_read(buf_addr, buf_before);
		for (int f = 0; f < e.n; f++) send_rx(e.data[(f % 4)*8 +: 8], e.stop);
		if (e.stop) begin
			check_rx();
		end else begin
			// Bad frames leave memory alone
			core_read(mem_map_pkg::RX_COUNT_ADDR, rd);
			check_word("rx count word after frame error", rd, cnt_before);
			core_read(buf_addr, rd);
			check_word("rx buffer word after frame error", rd, buf_before);
			check_count("rx_byte pulses", n_rx_byte, exp_rx_bytes);
		end
		check_count("rx_err pulses", n_rx_err, exp_rx_errs);
	endtask

	task automatic add_entry(input kind_t kind, input int n, input mem_map_pkg::word_t data,
			input logic stop, input logic rnd, input int ovl);
		entry_t e;
		e = '0;
		e.kind = kind;
		e.n = n;
		e.data = data;
		e.stop = stop;
		e.rnd = rnd;
		e.ovl = ovl;
		tbl.push_back(e);
	endtask

	task automatic build_table();
		entry_t e;
		// Every byte enable pattern, disabled lanes keep the base word
		for (int p = 0; p < 16; p++) begin
			e = '0;
			e.kind = K_CORE;
			e.data = 32'ha5b6_c7d8;
			e.be = 4'(p);
			e.exp = CORE_BASE;
			for (int l = 0; l < 4; l++) begin
				if (e.be[l]) e.exp[l*8 +: 8] = e.data[l*8 +: 8];
			end
			tbl.push_back(e);
		end
		add_entry(K_RX, 4, 32'h5a0f_c381, 1'b1, 1'b0, 0);
		add_entry(K_TX, 3, 32'hd4c3_b2a1, 1'b1, 1'b0, 0);
		// Low stop bit
		add_entry(K_RX, 1, 32'h0000_00e7, 1'b0, 1'b0, 0);
		add_entry(K_TX, 0, 32'h0000_0000, 1'b1, 1'b0, 0);
		add_entry(K_RX, 3, 32'h0042_ff00, 1'b1, 1'b0, 0);
		// Random payload with receive traffic on top
		add_entry(K_TX, 11, 32'h9c3e_7714, 1'b1, 1'b1, 4);
	endtask

	// Transmit line model, samples at mid-bit
	initial begin : tx_monitor
		uart_pkg::byte_t b;
		forever begin
			@(negedge CLK_BUF);
			if (!reset_i && tx_line === 1'b0) begin
				repeat (BIT_CLKS / 2) @(negedge CLK_BUF);
				if (tx_line !== 1'b0) begin
					$display("Start bit on uart_tx_o did not last to mid-bit at %0d ns", $time);
					stop_run();
				end
				for (int i = 0; i < 8; i++) begin
					repeat (BIT_CLKS) @(negedge CLK_BUF);
					b[i] = tx_line;
				end
				repeat (BIT_CLKS) @(negedge CLK_BUF);
				if (tx_line !== 1'b1) begin
					$display("Stop bit on uart_tx_o was not high at %0d ns", $time);
					stop_run();
				end
				tx_seen.push_back(b);
			end
		end
	end

	// Interrupt tallies and bound assertion status
	initial begin : int_counter
		forever begin
			@(negedge CLK_BUF);
			if (!reset_i) begin
				if (int_sig.tx_done === 1'b1) n_tx_done++;
				if (int_sig.rx_byte === 1'b1) n_rx_byte++;
				if (int_sig.rx_err === 1'b1) n_rx_err++;
			end
			if (u_dut.u_assertions.fail_cnt != 0) begin
				$display("A bound protocol assertion failed at %0d ns", $time);
				stop_run();
			end
		end
	end

	initial begin : watchdog
		wait (limit_ns > 0);
		#(limit_ns);
		$display("Watchdog expired after %0d ns, the DUT never finished a command", limit_ns);
		stop_run();
	end

	initial begin : main
		mem_map_pkg::word_t rd;
		reset_i = 1'b1;
		rx_line = 1'b1;
		core_req = '0;
		build_table();
		foreach (tbl[i]) frames += (tbl[i].kind == K_CORE) ? 0 : tbl[i].n + tbl[i].ovl;
		limit_ns = 2 * longint'(frames) * 10 * BIT_CLKS * CLK_PERIOD + 20000;
		repeat (4) @(posedge CLK_BUF);
		#2;
		reset_i = 1'b0;
		@(negedge CLK_BUF);
		check_int("int_sig_o after reset", int_sig, '0);
		if (tx_line !== 1'b1) begin
			$display("FAILED at %0d ns: uart_tx_o got %b, expected 1", $time, tx_line);
			stop_run();
		end
		// Mailbox, count word and start of the receive buffer
		core_write(mem_map_pkg::TX_CTRL_ADDR, 4'hf, '0);
		core_write(mem_map_pkg::RX_COUNT_ADDR, 4'hf, '0);
		for (int k = 0; k < 4; k++) begin
			core_write(mem_map_pkg::RX_BASE_ADDR + mem_map_pkg::addr_t'(k), 4'hf, '0);
		end
		foreach (tbl[i]) begin
			case (tbl[i].kind)
				K_CORE: run_core(tbl[i]);
				K_TX: run_tx(tbl[i]);
				default: run_rx(tbl[i]);
			endcase
		end
		repeat (4) @(negedge CLK_BUF);
		check_int("int_sig_o when idle", int_sig, '0);
		core_read(mem_map_pkg::RX_COUNT_ADDR, rd);
		check_word("final rx count word", rd, {24'd0, rx_count});
		// No stray pulses anywhere in the run
		check_count("tx_done pulses in total", n_tx_done, exp_tx_done);
		check_count("rx_byte pulses in total", n_rx_byte, exp_rx_bytes);
		check_count("rx_err pulses in total", n_rx_err, exp_rx_errs);
		if (u_dut.u_assertions.fail_cnt == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			stop_run();
		end
	end

endmodule

//--- uart_mcont.f
verilog/mem_map_pkg.sv
verilog/uart_pkg.sv
verilog/data_mem.sv
verilog/tx_fetch.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/rx_writeback.sv
verilog/uart_mcont_top.sv
dv/uart_mcont_assertions.sv
dv/uart_mcont_tb.sv

//--- verilog/data_mem.sv
// Two-port byte-writable data memory, core on one port and arbitrated UART stages on the other
`timescale 1ns/1ps

module data_mem (
	input  logic                  CLK_BUF,
	input  mem_map_pkg::mem_req_t core_req_i,
	output mem_map_pkg::word_t    core_rdata_o,
	input  mem_map_pkg::mem_req_t rx_req_i,
	input  logic                  rx_req_valid_i,
	input  mem_map_pkg::mem_req_t tx_req_i,
	input  logic                  tx_req_valid_i,
	output logic                  rx_grant_o,
	output logic                  tx_grant_o,
	output mem_map_pkg::word_t    ctrl_rdata_o
);

	mem_map_pkg::word_t mem [mem_map_pkg::MEM_DEPTH];
	mem_map_pkg::mem_req_t ctrl_req;
	logic ctrl_active;

	// Fixed priority, receive path first
	always_comb begin
		rx_grant_o = rx_req_valid_i;
		tx_grant_o = tx_req_valid_i & ~rx_req_valid_i;
		ctrl_active = rx_req_valid_i | tx_req_valid_i;
		ctrl_req = rx_req_valid_i ? rx_req_i : tx_req_i;
	end

	// Core port, read returns old data on a write
	always @(posedge CLK_BUF) begin
		for (int i = 0; i < mem_map_pkg::BE_W; i++) begin
			if (core_req_i.be[i]) begin
				mem[core_req_i.addr][i*8 +: 8] <= core_req_i.wdata[i*8 +: 8];
			end
		end
		core_rdata_o <= mem[core_req_i.addr];
	end

	// Controller port
	// Writes only when a stage holds the grant
	always @(posedge CLK_BUF) begin
		for (int i = 0; i < mem_map_pkg::BE_W; i++) begin
			if (ctrl_active && ctrl_req.be[i]) begin
				mem[ctrl_req.addr][i*8 +: 8] <= ctrl_req.wdata[i*8 +: 8];
			end
		end
		ctrl_rdata_o <= mem[ctrl_req.addr];
	end

endmodule

//--- verilog/mem_map_pkg.sv
// Data memory map and port types, referenced by scoped name from the memory, UART stages and top
package mem_map_pkg;

	// Memory geometry
	localparam int WORD_W = 32;
	localparam int ADDR_W = 11;
	localparam int BE_W = 4;
	localparam int MEM_DEPTH = 2048;

	// One data memory word
	typedef logic [WORD_W-1:0] word_t;
	// Word address, same width as the controller address
	typedef logic [ADDR_W-1:0] addr_t;
	// One enable per byte lane, all zero means read
	typedef logic [BE_W-1:0] byte_en_t;

	// One access on any memory port, 47 bits
	typedef struct packed {
		addr_t    addr;
		byte_en_t be;
		word_t    wdata;
	} mem_req_t;

	// Transmit mailbox word
	localparam addr_t TX_CTRL_ADDR = 11'd0;
	// Count of received bytes, wraps at 256
	localparam addr_t RX_COUNT_ADDR = 11'd1023;
	// Receive buffer, four bytes per word, little-endian
	localparam addr_t RX_BASE_ADDR = 11'd1024;

	// Transmit control word as stored, or split into fields
	typedef union packed {
		word_t raw;
		struct packed {
			logic        go;
			logic [11:0] rsvd;
			logic [7:0]  len;
			addr_t       start;
		} fields;
	} tx_ctrl_u;

	// Interrupt vector
	localparam int INT_W = 3;
	typedef struct packed {
		logic tx_done;
		logic rx_byte;
		logic rx_err;
	} int_sig_t;

endpackage

//--- verilog/rx_writeback.sv
// Receive writeback stage, stores each good byte and the byte count and raises receive interrupts
`timescale 1ns/1ps

module rx_writeback (
	input  logic                  CLK_BUF,
	input  logic                  reset_i,
	input  logic                  frame_valid_i,
	input  uart_pkg::rx_frame_t   frame_i,
	output mem_map_pkg::mem_req_t req_o,
	output logic                  req_valid_o,
	output logic                  rx_byte_o,
	output logic                  rx_err_o
);

	// Count of good bytes, wraps at 256
	logic [7:0] count_q;
	logic byte_pend_q;
	logic cnt_pend_q;
	logic err_q;
	uart_pkg::byte_t data_q;

	always_ff @(posedge CLK_BUF) begin
		if (reset_i) begin
			count_q <= '0;
			byte_pend_q <= 1'b0;
			cnt_pend_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			byte_pend_q <= frame_valid_i & ~frame_i.frame_err;
			err_q <= frame_valid_i & frame_i.frame_err;
			// Count word goes out the cycle after the byte
			cnt_pend_q <= byte_pend_q;
			if (byte_pend_q) count_q <= count_q + 8'd1;
		end
	end

	always_ff @(posedge CLK_BUF) begin
		if (frame_valid_i) data_q <= frame_i.data;
	end

	// Byte lane write first, then the full count word
	always_comb begin
		if (byte_pend_q) begin
			req_o.addr = mem_map_pkg::RX_BASE_ADDR + {5'd0, count_q[7:2]};
			req_o.be = 4'b0001 << count_q[1:0];
			req_o.wdata = {4{data_q}};
		end else begin
			req_o.addr = mem_map_pkg::RX_COUNT_ADDR;
			req_o.be = '1;
			req_o.wdata = {24'd0, count_q};
		end
	end

	assign req_valid_o = byte_pend_q | cnt_pend_q;
	assign rx_byte_o = cnt_pend_q;
	assign rx_err_o = err_q;

endmodule

//--- verilog/tx_fetch.sv
// Transmit fetch stage, polls the mailbox and feeds buffer bytes to the UART serializer
`timescale 1ns/1ps

module tx_fetch (
	input  logic                  CLK_BUF,
	input  logic                  reset_i,
	output mem_map_pkg::mem_req_t req_o,
	output logic                  req_valid_o,
	input  logic                  grant_i,
	input  mem_map_pkg::word_t    rdata_i,
	output logic                  tx_start_o,
	output uart_pkg::byte_t       tx_byte_o,
	input  logic                  tx_busy_i,
	output logic                  tx_done_o
);

	typedef enum logic [2:0] {
		S_POLL, S_POLL_RD, S_CLEAR, S_FETCH, S_FETCH_RD, S_SEND, S_DRAIN
	} state_t;

	state_t state_q;
	mem_map_pkg::tx_ctrl_u rd_ctrl;
	mem_map_pkg::tx_ctrl_u cmd_q;
	mem_map_pkg::tx_ctrl_u clr_ctrl;
	mem_map_pkg::addr_t buf_addr_q;
	mem_map_pkg::word_t word_q;
	logic [7:0] remain_q;
	logic [1:0] lane_q;
	logic send_fire;

	// Request per state, held until granted
	always_comb begin
		rd_ctrl.raw = rdata_i;
		clr_ctrl = cmd_q;
		clr_ctrl.fields.go = 1'b0;
		req_o = '0;
		req_valid_o = 1'b0;
		case (state_q)
			S_POLL: begin
				req_valid_o = 1'b1;
				req_o.addr = mem_map_pkg::TX_CTRL_ADDR;
			end
			S_CLEAR: begin
				// Write back the command with go dropped
				req_valid_o = 1'b1;
				req_o.addr = mem_map_pkg::TX_CTRL_ADDR;
				req_o.be = '1;
				req_o.wdata = clr_ctrl.raw;
			end
			S_FETCH: begin
				req_valid_o = 1'b1;
				req_o.addr = buf_addr_q;
			end
			default: begin
			end
		endcase
	end

	assign send_fire = (state_q == S_SEND) && !tx_busy_i;
	assign tx_start_o = send_fire;
	// Lanes go out low byte first
	assign tx_byte_o = word_q[lane_q*8 +: 8];
	assign tx_done_o = (state_q == S_DRAIN) && !tx_busy_i;

	always_ff @(posedge CLK_BUF) begin
		if (reset_i) begin
			state_q <= S_POLL;
			remain_q <= '0;
			lane_q <= '0;
		end else begin
			case (state_q)
				S_POLL: if (grant_i) state_q <= S_POLL_RD;
				S_POLL_RD: begin
					if (rd_ctrl.fields.go) begin
						remain_q <= rd_ctrl.fields.len;
						lane_q <= '0;
						state_q <= S_CLEAR;
					end else begin
						state_q <= S_POLL;
					end
				end
				// Zero length goes straight to done
				S_CLEAR: if (grant_i) state_q <= (remain_q == 8'd0) ? S_DRAIN : S_FETCH;
				S_FETCH: if (grant_i) state_q <= S_FETCH_RD;
				S_FETCH_RD: state_q <= S_SEND;
				S_SEND: begin
					if (send_fire) begin
						remain_q <= remain_q - 8'd1;
						lane_q <= lane_q + 2'd1;
						if (remain_q == 8'd1) state_q <= S_DRAIN;
						else if (lane_q == 2'd3) state_q <= S_FETCH;
					end
				end
				// Wait for the last stop bit
				S_DRAIN: if (!tx_busy_i) state_q <= S_POLL;
				default: state_q <= S_POLL;
			endcase
		end
	end

	// Command, address and word registers
	always_ff @(posedge CLK_BUF) begin
		if (state_q == S_POLL_RD) begin
			cmd_q <= rd_ctrl;
			buf_addr_q <= rd_ctrl.fields.start;
		end
		if (state_q == S_FETCH_RD) word_q <= rdata_i;
		if (send_fire && lane_q == 2'd3) buf_addr_q <= buf_addr_q + 1'b1;
	end

endmodule

//--- verilog/uart_mcont_top.sv
// UART controller subsystem top, joins the data memory with the transmit and receive paths
`timescale 1ns/1ps

module uart_mcont_top (
	input  logic                  CLK_BUF,
	input  logic                  reset_i,
	input  mem_map_pkg::mem_req_t core_req_i,
	output mem_map_pkg::word_t    core_rdata_o,
	input  logic                  uart_rx_i,
	output logic                  uart_tx_o,
	output mem_map_pkg::int_sig_t int_sig_o
);

	// Controller port
	mem_map_pkg::mem_req_t tx_req;
	mem_map_pkg::mem_req_t rx_req;
	mem_map_pkg::word_t ctrl_rdata;
	logic tx_req_valid;
	logic rx_req_valid;
	logic tx_grant;

	// Transmit path
	logic tx_start;
	uart_pkg::byte_t tx_byte;
	logic tx_busy;
	logic tx_done;

	// Receive path
	logic frame_valid;
	uart_pkg::rx_frame_t frame;
	logic rx_byte;
	logic rx_err;

	logic [mem_map_pkg::INT_W-1:0] int_pulse;

	// Receive path has top priority and needs no grant
	data_mem u_mem (
		.CLK_BUF(CLK_BUF), .core_req_i(core_req_i), .core_rdata_o(core_rdata_o),
		.rx_req_i(rx_req), .rx_req_valid_i(rx_req_valid),
		.tx_req_i(tx_req), .tx_req_valid_i(tx_req_valid),
		.rx_grant_o(), .tx_grant_o(tx_grant), .ctrl_rdata_o(ctrl_rdata)
	);

	tx_fetch u_tx_fetch (
		.CLK_BUF(CLK_BUF), .reset_i(reset_i), .req_o(tx_req), .req_valid_o(tx_req_valid),
		.grant_i(tx_grant), .rdata_i(ctrl_rdata), .tx_start_o(tx_start),
		.tx_byte_o(tx_byte), .tx_busy_i(tx_busy), .tx_done_o(tx_done)
	);

	uart_tx u_uart_tx (
		.CLK_BUF(CLK_BUF), .reset_i(reset_i), .tx_start_i(tx_start),
		.tx_byte_i(tx_byte), .tx_busy_o(tx_busy), .uart_tx_o(uart_tx_o)
	);

	uart_rx u_uart_rx (
		.CLK_BUF(CLK_BUF), .reset_i(reset_i), .uart_rx_i(uart_rx_i),
		.frame_valid_o(frame_valid), .frame_o(frame)
	);

	rx_writeback u_rx_wb (
		.CLK_BUF(CLK_BUF), .reset_i(reset_i), .frame_valid_i(frame_valid), .frame_i(frame),
		.req_o(rx_req), .req_valid_o(rx_req_valid), .rx_byte_o(rx_byte), .rx_err_o(rx_err)
	);

	// Interrupt vector in struct order
	assign int_pulse = {tx_done, rx_byte, rx_err};
	assign int_sig_o = mem_map_pkg::int_sig_t'(int_pulse);

endmodule

//--- verilog/uart_pkg.sv
// UART bit timing and frame types, referenced by scoped name from the serial stages
package uart_pkg;

	// Bit period in clocks, short for fast simulation
	localparam int CLKS_PER_BIT = 8;
	localparam int HALF_BIT = CLKS_PER_BIT / 2;
	// Start bit, eight data bits, one stop bit
	localparam int DATA_BITS = 8;
	localparam int FRAME_BITS = 10;

	localparam int CLK_CNT_W = $clog2(CLKS_PER_BIT);
	localparam int BIT_CNT_W = $clog2(FRAME_BITS);
	typedef logic [CLK_CNT_W-1:0] clk_cnt_t;
	typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

	// Counter end values
	localparam clk_cnt_t CNT_BIT_END = clk_cnt_t'(CLKS_PER_BIT - 1);
	localparam clk_cnt_t CNT_MID_START = clk_cnt_t'(HALF_BIT - 1);
	// Stop bit check ends early to absorb the synchronizer delay
	localparam clk_cnt_t CNT_STOP_END = clk_cnt_t'(CLKS_PER_BIT - 2);
	localparam bit_cnt_t LAST_FRAME_BIT = bit_cnt_t'(FRAME_BITS - 1);
	localparam bit_cnt_t LAST_DATA_BIT = bit_cnt_t'(DATA_BITS - 1);

	typedef logic [DATA_BITS-1:0] byte_t;

	// Received byte and stop bit status, 9 bits
	typedef struct packed {
		byte_t data;
		logic  frame_err;
	} rx_frame_t;

endpackage

//--- verilog/uart_rx.sv
// UART deserializer, samples frames at mid-bit and strobes each byte with its stop bit status
`timescale 1ns/1ps

module uart_rx (
	input  logic                CLK_BUF,
	input  logic                reset_i,
	input  logic                uart_rx_i,
	output logic                frame_valid_o,
	output uart_pkg::rx_frame_t frame_o
);

	typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

	state_t state_q;
	logic rx_meta_q;
	logic rx_sync_q;
	uart_pkg::clk_cnt_t clk_cnt_q;
	uart_pkg::bit_cnt_t bit_idx_q;
	uart_pkg::byte_t data_q;
	logic err_q;
	logic valid_q;

	assign frame_valid_o = valid_q;
	assign frame_o.data = data_q;
	assign frame_o.frame_err = err_q;

	// Two-flop synchronizer, idles high
	always_ff @(posedge CLK_BUF) begin
		if (reset_i) begin
			rx_meta_q <= 1'b1;
			rx_sync_q <= 1'b1;
		end else begin
			rx_meta_q <= uart_rx_i;
			rx_sync_q <= rx_meta_q;
		end
	end

	always_ff @(posedge CLK_BUF) begin
		if (reset_i) begin
			state_q <= S_IDLE;
			clk_cnt_q <= '0;
			bit_idx_q <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state_q)
				S_IDLE: begin
					clk_cnt_q <= '0;
					bit_idx_q <= '0;
					if (!rx_sync_q) state_q <= S_START;
				end
				S_START: begin
					if (clk_cnt_q == uart_pkg::CNT_MID_START) begin
						clk_cnt_q <= '0;
						// Line back high at mid-bit means a glitch
						state_q <= rx_sync_q ? S_IDLE : S_DATA;
					end else begin
						clk_cnt_q <= clk_cnt_q + 1'b1;
					end
				end
				S_DATA: begin
					if (clk_cnt_q == uart_pkg::CNT_BIT_END) begin
						clk_cnt_q <= '0;
						bit_idx_q <= bit_idx_q + 1'b1;
						if (bit_idx_q == uart_pkg::LAST_DATA_BIT) state_q <= S_STOP;
					end else begin
						clk_cnt_q <= clk_cnt_q + 1'b1;
					end
				end
				S_STOP: begin
					if (clk_cnt_q == uart_pkg::CNT_STOP_END) begin
						valid_q <= 1'b1;
						state_q <= S_IDLE;
					end else begin
						clk_cnt_q <= clk_cnt_q + 1'b1;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// Shift data in from the top, stop bit low is a frame error
	always_ff @(posedge CLK_BUF) begin
		if (state_q == S_DATA && clk_cnt_q == uart_pkg::CNT_BIT_END) begin
			data_q <= {rx_sync_q, data_q[uart_pkg::DATA_BITS-1:1]};
		end
		if (state_q == S_STOP && clk_cnt_q == uart_pkg::CNT_STOP_END) err_q <= ~rx_sync_q;
	end

endmodule

//--- verilog/uart_tx.sv
// UART serializer, sends one byte per start strobe as start, eight data and one stop bit
`timescale 1ns/1ps

module uart_tx (
	input  logic            CLK_BUF,
	input  logic            reset_i,
	input  logic            tx_start_i,
	input  uart_pkg::byte_t tx_byte_i,
	output logic            tx_busy_o,
	output logic            uart_tx_o
);

	logic busy_q;
	logic line_q;
	uart_pkg::clk_cnt_t clk_cnt_q;
	uart_pkg::bit_cnt_t bit_idx_q;
	// Data bits then stop bit
	logic [uart_pkg::DATA_BITS:0] shift_q;
	logic bit_end;

	assign bit_end = (clk_cnt_q == uart_pkg::CNT_BIT_END);
	assign tx_busy_o = busy_q;
	assign uart_tx_o = line_q;

	always_ff @(posedge CLK_BUF) begin
		if (reset_i) begin
			busy_q <= 1'b0;
			line_q <= 1'b1;
			clk_cnt_q <= '0;
			bit_idx_q <= '0;
		end else if (!busy_q) begin
			clk_cnt_q <= '0;
			bit_idx_q <= '0;
			// Start bit on the next cycle
			if (tx_start_i) begin
				busy_q <= 1'b1;
				line_q <= 1'b0;
			end
		end else if (bit_end) begin
			clk_cnt_q <= '0;
			if (bit_idx_q == uart_pkg::LAST_FRAME_BIT) begin
				// Stop bit finished, line stays high
				busy_q <= 1'b0;
			end else begin
				line_q <= shift_q[0];
				bit_idx_q <= bit_idx_q + 1'b1;
			end
		end else begin
			clk_cnt_q <= clk_cnt_q + 1'b1;
		end
	end

	// LSB first, ones fill in behind
	always_ff @(posedge CLK_BUF) begin
		if (!busy_q && tx_start_i) begin
			shift_q <= {1'b1, tx_byte_i};
		end else if (busy_q && bit_end) begin
			shift_q <= {1'b1, shift_q[uart_pkg::DATA_BITS:1]};
		end
	end

endmodule
